// ==== Bender.yml ====
package:
  name: lexicon

sources:
  - files:
      - hw/lexicon_pkg.sv
      - hw/lexicon_if.sv
      - hw/char_ram.sv
      - hw/lexicon_regs.sv
      - hw/word_matcher.sv
      - hw/lexicon_top.sv
  - target: test
    files:
      - bench/tb_clock.sv
      - bench/lexicon_tb.sv

// ==== bench/lexicon_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lexicon_tb;
    import lexicon_pkg::*;

    localparam int vocab_addr_w = 8;
    localparam int query_addr_w = 4;
    localparam int vocab_depth  = 2 ** vocab_addr_w;
    localparam int base         = 16;
    localparam int num_cases    = 12;
    localparam int done_timeout = 2000;

    logic                    clk;
    logic                    rst_n;
    logic                    mem_we;
    logic                    mem_sel;
    logic [vocab_addr_w-1:0] mem_addr;
    logic [char_w-1:0]       mem_wdata;
    logic                    reg_we;
    reg_addr_e               reg_addr;
    logic [15:0]             reg_wdata;
    logic [31:0]             reg_rdata;
    logic                    done;

    int          errors;
    int          checks;
    int          done_count;
    logic [31:0] rnd_state;

    // ======================================================================
    // Case table
    // ======================================================================

    // Vocabulary text uses | for the zero terminator; bounds are offsets from base.
    string vocab_tab [num_cases] = '{
        "cat|dog|bird|fish|", "cat|dog|bird|fish|", "cat|dog|bird|fish|",
        "cat|dog|bird|fish|", "cat|dog|bird|fish|", "ab||cd|", "ab|cd|",
        "cat|dog|bird|fish|", "cat|dog|bird|fish|", "cat|dog|bird|fish|",
        "cat|dog|bird|fish|", "cat|dog|bird|fish|"
    };
    int    start_tab [num_cases] = '{0, 0, 0, 0, 0, 0, 0, 4, 4, 4, 4, 0};
    int    end_tab   [num_cases] = '{18, 18, 18, 18, 18, 7, 6, 13, 13, 12, 4, 18};
    string query_tab [num_cases] = '{
        "bird", "cow", "cat", "bir", "birds", "", "",
        "bird", "cat", "bird", "dog", "fish"
    };
    bit    hit_tab   [num_cases] = '{1, 0, 1, 0, 0, 1, 0, 1, 0, 0, 0, 1};
    int    index_tab [num_cases] = '{2, 0, 0, 0, 0, 1, 0, 1, 0, 0, 0, 3};

    tb_clock #(.period(4), .reset_cycles(4)) tb_clock_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    lexicon_top #(
        .vocab_addr_w (vocab_addr_w),
        .query_addr_w (query_addr_w)
    ) lexicon_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_we    (mem_we),
        .mem_sel   (mem_sel),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .reg_we    (reg_we),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .done      (done)
    );

    // Done is one cycle wide, so each pulse is seen at one falling edge.
    always @(negedge clk) begin
        if (done === 1'b1) begin
            done_count++;
        end
    end

    // ======================================================================
    // Helpers
    // ======================================================================

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [char_w-1:0] text_char(input string s, input int pos);
        if (s[pos] == "|") begin
            return '0;
        end
        return s[pos];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic mem_write(input logic sel, input int addr, input logic [char_w-1:0] data);
        @(negedge clk);
        mem_we    = 1'b1;
        mem_sel   = sel;
        mem_addr  = addr[vocab_addr_w-1:0];
        mem_wdata = data;
    endtask

    task automatic reg_write(input reg_addr_e addr, input logic [15:0] data);
        @(negedge clk);
        reg_we    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
    endtask

    // Readback is sampled one falling edge after the address.
    task automatic reg_read(input reg_addr_e addr, output logic [31:0] data);
        @(negedge clk);
        reg_we   = 1'b0;
        reg_addr = addr;
        @(negedge clk);
        data = reg_rdata;
    endtask

    task automatic wait_reset();
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1 && cycles < 100) begin
            @(negedge clk);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            errors++;
            $display("Reset never released after %0d cycles.", cycles);
        end
    endtask

    task automatic load_case(input int n);
        string vocab;
        string query;
        int    a;
        vocab = vocab_tab[n];
        query = query_tab[n];
        // Nonzero noise around the text.
        for (a = 0; a < vocab_depth; a++) begin
            rnd_state = xorshift(rnd_state);
            mem_write(1'b0, a, rnd_state[7:0] | 8'h80);
        end
        for (a = 0; a < vocab.len(); a++) begin
            mem_write(1'b0, base + a, text_char(vocab, a));
        end
        for (a = 0; a < query.len(); a++) begin
            mem_write(1'b1, a, query[a]);
        end
        mem_write(1'b1, query.len(), 8'h00);
        @(negedge clk);
        mem_we = 1'b0;
    endtask

    // Busy must read high on every cycle until done.
    task automatic wait_done();
        int      cycles;
        status_t st;
        cycles = 0;
        @(negedge clk);
        while (done !== 1'b1 && cycles < done_timeout) begin
            st = reg_rdata[$bits(status_t)-1:0];
            check_value("status.busy", 32'(st.busy), 32'h1);
            cycles++;
            @(negedge clk);
        end
        if (done !== 1'b1) begin
            errors++;
            $display("Timed out after %0d cycles waiting for done.", cycles);
        end
    endtask

    task automatic check_result(input int n);
        status_t st;
        st = reg_rdata[$bits(status_t)-1:0];
        check_value("status.busy", 32'(st.busy), 32'h0);
        check_value("status.hit", 32'(st.hit), 32'(hit_tab[n]));
        check_value("status.word_index", 32'(st.word_index), index_tab[n]);
    endtask

    task automatic run_case(input int n);
        load_case(n);
        reg_write(REG_START_ADDR, 16'(base + start_tab[n]));
        reg_write(REG_END_ADDR, 16'(base + end_tab[n]));
        done_count = 0;
        reg_write(REG_CTRL, 16'h0001);
        // Lands while the first launch is pending and must be dropped.
        reg_write(REG_CTRL, 16'h0001);
        @(negedge clk);
        reg_we   = 1'b0;
        reg_addr = REG_STATUS;
        wait_done();
        // Result is valid in the cycle that done is high.
        check_result(n);
        repeat (8) @(negedge clk);
        check_value("done_count", done_count, 32'h1);
        check_result(n);
    endtask

    // ======================================================================
    // Sequence
    // ======================================================================

    initial begin
        logic [31:0] rd;
        int          n;
        errors     = 0;
        checks     = 0;
        done_count = 0;
        rnd_state  = 32'h2800_191f;
        mem_we     = 1'b0;
        mem_sel    = 1'b0;
        mem_addr   = '0;
        mem_wdata  = '0;
        reg_we     = 1'b0;
        reg_addr   = REG_STATUS;
        reg_wdata  = '0;

        wait_reset();
        repeat (4) @(negedge clk);
        reg_read(REG_STATUS, rd);
        check_value("reg_rdata", rd, 32'h0);
        reg_read(REG_START_ADDR, rd);
        check_value("reg_rdata", rd, 32'h0);
        reg_read(REG_END_ADDR, rd);
        check_value("reg_rdata", rd, 32'h0);
        check_value("done_count", done_count, 32'h0);

        for (n = 0; n < num_cases; n++) begin
            run_case(n);
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int period       = 4,
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // Release on a falling edge, clear of the active edge.
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== build.f ====
hw/lexicon_pkg.sv
hw/lexicon_if.sv
hw/char_ram.sv
hw/lexicon_regs.sv
hw/word_matcher.sv
hw/lexicon_top.sv
bench/tb_clock.sv
bench/lexicon_tb.sv

// ==== hw/char_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module char_ram #(
    parameter int addr_w = 8
) (
    input  logic                             clk,
    input  logic                             we,
    input  logic [addr_w-1:0]                waddr,
    input  logic [lexicon_pkg::char_w-1:0]   wdata,
    input  logic [addr_w-1:0]                raddr,
    output logic [lexicon_pkg::char_w-1:0]   rdata
);
    import lexicon_pkg::*;

    localparam int depth = 2 ** addr_w;

    logic [char_w-1:0] mem [depth];

    // Host side.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read with data one cycle after the address.
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

// ==== hw/lexicon_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface lexicon_if #(
    parameter int vocab_addr_w = 8
) ();
    import lexicon_pkg::*;

    // Launch and region bounds.
    logic                    start;
    logic [vocab_addr_w-1:0] start_addr;
    logic [vocab_addr_w-1:0] end_addr;

    // Search progress and result.
    logic                    busy;
    logic                    done;
    logic                    hit;
    logic [idx_w-1:0]        word_index;

    modport regs (
        output start, start_addr, end_addr,
        input  busy, done, hit, word_index
    );

    modport matcher (
        input  start, start_addr, end_addr,
        output busy, done, hit, word_index
    );

endinterface

`default_nettype wire

// ==== hw/lexicon_pkg.sv ====
`default_nettype none

package lexicon_pkg;

    // ======================================================================
    // Widths
    // ======================================================================

    // One character of vocabulary or query text.
    localparam int char_w = 8;

    // Word ordinal as reported in the status register.
    localparam int idx_w = 16;

    // ======================================================================
    // Register map
    // ======================================================================

    // Launch bit in REG_CTRL.
    localparam int ctrl_start_bit = 0;

    typedef enum logic [1:0] {
        REG_CTRL       = 2'd0,
        REG_START_ADDR = 2'd1,
        REG_END_ADDR   = 2'd2,
        REG_STATUS     = 2'd3
    } reg_addr_e;

    // Status word, busy in the top bit.
    typedef struct packed {
        logic             busy;
        logic             hit;
        logic [idx_w-1:0] word_index;
    } status_t;

endpackage

`default_nettype wire

// ==== hw/lexicon_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module lexicon_regs #(
    parameter int vocab_addr_w = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  reg_we,
    input  lexicon_pkg::reg_addr_e reg_addr,
    input  logic [15:0]           reg_wdata,
    output logic [31:0]           reg_rdata,
    lexicon_if.regs               ctl
);
    import lexicon_pkg::*;

    logic    launch_q;
    logic    ctrl_write;
    logic    pending;
    status_t status;

    // ======================================================================
    // Launch path
    // ======================================================================

    assign ctrl_write = reg_we && (reg_addr == REG_CTRL) && reg_wdata[ctrl_start_bit];

    // A search is in flight from the write until done.
    assign pending = launch_q | ctl.start | ctl.busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            launch_q  <= 1'b0;
            ctl.start <= 1'b0;
        end else begin
            launch_q  <= ctrl_write && !pending;
            ctl.start <= launch_q;
        end
    end

    // Region bounds.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctl.start_addr <= '0;
            ctl.end_addr   <= '0;
        end else if (reg_we) begin
            if (reg_addr == REG_START_ADDR) begin
                ctl.start_addr <= reg_wdata[vocab_addr_w-1:0];
            end
            if (reg_addr == REG_END_ADDR) begin
                ctl.end_addr <= reg_wdata[vocab_addr_w-1:0];
            end
        end
    end

    // ======================================================================
    // Status readback
    // ======================================================================

    // The matcher holds its result from done until the next start.
    always_comb begin
        status.busy       = pending;
        status.hit        = ctl.hit;
        status.word_index = ctl.word_index;
    end

    always_comb begin
        unique case (reg_addr)
            REG_START_ADDR: reg_rdata = 32'(ctl.start_addr);
            REG_END_ADDR:   reg_rdata = 32'(ctl.end_addr);
            REG_STATUS:     reg_rdata = 32'(status);
            default:        reg_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/lexicon_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lexicon_top #(
    parameter int vocab_addr_w = 8,
    parameter int query_addr_w = 4
) (
    input  logic                           clk,
    input  logic                           rst_n,
    // Host memory load.
    input  logic                           mem_we,
    input  logic                           mem_sel,
    input  logic [vocab_addr_w-1:0]        mem_addr,
    input  logic [lexicon_pkg::char_w-1:0] mem_wdata,
    // Register access.
    input  logic                           reg_we,
    input  lexicon_pkg::reg_addr_e         reg_addr,
    input  logic [15:0]                    reg_wdata,
    output logic [31:0]                    reg_rdata,
    output logic                           done
);
    import lexicon_pkg::*;

    logic                    vocab_we;
    logic                    query_we;
    logic [vocab_addr_w-1:0] vocab_raddr;
    logic [query_addr_w-1:0] query_raddr;
    logic [char_w-1:0]       vocab_rdata;
    logic [char_w-1:0]       query_rdata;

    lexicon_if #(.vocab_addr_w(vocab_addr_w)) ctl_if ();

    // mem_sel picks the query memory when high.
    assign vocab_we = mem_we && !mem_sel;
    assign query_we = mem_we && mem_sel;

    assign done = ctl_if.done;

    char_ram #(.addr_w(vocab_addr_w)) vocab_ram_i (
        .clk   (clk),
        .we    (vocab_we),
        .waddr (mem_addr),
        .wdata (mem_wdata),
        .raddr (vocab_raddr),
        .rdata (vocab_rdata)
    );

    char_ram #(.addr_w(query_addr_w)) query_ram_i (
        .clk   (clk),
        .we    (query_we),
        .waddr (mem_addr[query_addr_w-1:0]),
        .wdata (mem_wdata),
        .raddr (query_raddr),
        .rdata (query_rdata)
    );

    lexicon_regs #(.vocab_addr_w(vocab_addr_w)) lexicon_regs_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .reg_we    (reg_we),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .ctl       (ctl_if.regs)
    );

    word_matcher #(
        .vocab_addr_w (vocab_addr_w),
        .query_addr_w (query_addr_w)
    ) word_matcher_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .ctl         (ctl_if.matcher),
        .vocab_raddr (vocab_raddr),
        .vocab_rdata (vocab_rdata),
        .query_raddr (query_raddr),
        .query_rdata (query_rdata)
    );

endmodule

`default_nettype wire

// ==== hw/word_matcher.sv ====
`timescale 1ns/1ps
`default_nettype none

module word_matcher #(
    parameter int vocab_addr_w = 8,
    parameter int query_addr_w = 4
) (
    input  logic                           clk,
    input  logic                           rst_n,
    lexicon_if.matcher                     ctl,
    output logic [vocab_addr_w-1:0]        vocab_raddr,
    input  logic [lexicon_pkg::char_w-1:0] vocab_rdata,
    output logic [query_addr_w-1:0]        query_raddr,
    input  logic [lexicon_pkg::char_w-1:0] query_rdata
);
    import lexicon_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_COMPARE,
        ST_SKIP,
        ST_FINISH
    } state_e;

    state_e                  state;
    logic [vocab_addr_w-1:0] vptr;
    logic [vocab_addr_w-1:0] vptr_nxt;
    logic [query_addr_w-1:0] qptr;
    logic [idx_w-1:0]        word_cnt;
    logic                    fetch_wait;
    logic                    v_zero;
    logic                    q_zero;
    logic                    chars_equal;
    logic                    at_last;

    assign vocab_raddr = vptr;
    assign query_raddr = qptr;

    assign v_zero      = (vocab_rdata == '0);
    assign q_zero      = (query_rdata == '0);
    assign chars_equal = (vocab_rdata == query_rdata);
    assign vptr_nxt    = vptr + 1'b1;

    // Next vocabulary address falls off the region.
    assign at_last     = (vptr_nxt == ctl.end_addr);

    // ======================================================================
    // Search FSM
    // ======================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= ST_IDLE;
            vptr           <= '0;
            qptr           <= '0;
            word_cnt       <= '0;
            fetch_wait     <= 1'b0;
            ctl.busy       <= 1'b0;
            ctl.done       <= 1'b0;
            ctl.hit        <= 1'b0;
            ctl.word_index <= '0;
        end else begin
            ctl.done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (ctl.start) begin
                        vptr           <= ctl.start_addr;
                        qptr           <= '0;
                        word_cnt       <= '0;
                        ctl.busy       <= 1'b1;
                        ctl.hit        <= 1'b0;
                        ctl.word_index <= '0;
                        // Empty region is an immediate miss.
                        if (ctl.start_addr == ctl.end_addr) begin
                            state <= ST_FINISH;
                        end else begin
                            state <= ST_FETCH;
                        end
                    end
                end

                // Read latency of both memories.
                ST_FETCH: begin
                    state <= ST_COMPARE;
                end

                ST_COMPARE: begin
                    if (v_zero && q_zero) begin
                        ctl.hit        <= 1'b1;
                        ctl.word_index <= word_cnt;
                        state          <= ST_FINISH;
                    end else if (chars_equal) begin
                        vptr  <= vptr_nxt;
                        qptr  <= qptr + 1'b1;
                        state <= at_last ? ST_FINISH : ST_FETCH;
                    end else if (v_zero) begin
                        // Word shorter than the query, already at its end.
                        vptr     <= vptr_nxt;
                        qptr     <= '0;
                        word_cnt <= word_cnt + 1'b1;
                        state    <= at_last ? ST_FINISH : ST_FETCH;
                    end else begin
                        vptr       <= vptr_nxt;
                        qptr       <= '0;
                        fetch_wait <= 1'b1;
                        state      <= at_last ? ST_FINISH : ST_SKIP;
                    end
                end

                // Walk to the terminator of the mismatched word.
                ST_SKIP: begin
                    if (fetch_wait) begin
                        fetch_wait <= 1'b0;
                    end else begin
                        vptr <= vptr_nxt;
                        if (v_zero) begin
                            word_cnt <= word_cnt + 1'b1;
                            state    <= at_last ? ST_FINISH : ST_FETCH;
                        end else begin
                            fetch_wait <= 1'b1;
                            if (at_last) begin
                                state <= ST_FINISH;
                            end
                        end
                    end
                end

                ST_FINISH: begin
                    ctl.done <= 1'b1;
                    ctl.busy <= 1'b0;
                    state    <= ST_IDLE;
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // ======================================================================
    // Checks
    // ======================================================================

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        ctl.done |=> !ctl.done);

    // Register block holds launches back while a search runs.
    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        ctl.start |-> !ctl.busy);

    a_vptr_bound: assert property (@(posedge clk) disable iff (!rst_n)
        (state inside {ST_FETCH, ST_COMPARE, ST_SKIP}) |-> (vptr != ctl.end_addr));

endmodule

`default_nettype wire
